// File: sources.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_regs.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_top.sv
sim/uart_properties.sv
sim/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UART testbench with Verilator

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module uart_tb \
    -f sources.f --Mdir obj_dir -o uart_tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/uart_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: sim/uart_tb.sv
`timescale 1ns/100ps

module uart_tb;

  import uart_pkg::*;

  typedef struct packed {
    logic [7:0]  lcr;
    logic [15:0] div;
    logic        fifo;   // FCR enable for this row
    logic [7:0]  ch;
  } frame_row_t;

  localparam int unsigned NUM_ROWS = 8;
  localparam logic [7:0]  LSR_IDLE = 8'h60;  // THR empty and TX empty

  logic              clk;
  logic              arst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [7:0]        wb_dat_w;
  logic [7:0]        wb_dat_r;
  logic              wb_ack;
  logic              txd;

  frame_row_t        rows [NUM_ROWS];
  int unsigned       errors = 0;
  int unsigned       checks = 0;
  int unsigned       cycle_cnt = 0;
  int unsigned       cycle_limit;

  uart_top i_dut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .txd_o    (txd)
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_char(input logic [7:0] act, input logic [7:0] exp, input string msg);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %02h expected %02h", $time, msg, act, exp);
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string msg);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %b expected %b", $time, msg, act, exp);
    end
  endtask

  task automatic check_reg(input logic [7:0] act, input logic [7:0] exp, input string msg);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED @%0t: %s read %02h expected %02h", $time, msg, act, exp);
    end
  endtask

  task automatic check_len(input word_len_t act, input word_len_t exp, input string msg);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %s expected %s", $time, msg, act.name(), exp.name());
    end
  endtask

  ////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////

  task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [7:0] wdat, output logic [7:0] rdat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    @(negedge clk);
    while (wb_ack !== 1'b1) begin
      @(negedge clk);  // Watchdog covers a stuck slave
    end
    rdat = wb_dat_r;   // Valid while ack high
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [7:0] dat);
    bus_access(1'b0, adr, 8'h00, dat);
  endtask

  // LCR, divisor through DLAB, then FIFO mode
  task automatic set_line(input logic [7:0] lcr, input logic [15:0] div, input logic fifo);
    bus_write(REG_LCR, lcr | 8'h80);
    bus_write(REG_THR_DLL, div[7:0]);
    bus_write(REG_DLM, div[15:8]);
    bus_write(REG_LCR, lcr);
    bus_write(REG_FCR, {7'd0, fifo});
  endtask

  // Poll LSR until the shifter is idle
  task automatic wait_tx_idle(output logic [7:0] lsr);
    for (int unsigned i = 0; i < 40; i++) begin
      bus_read(REG_LSR, lsr);
      if (lsr[LSR_TX_EMPTY]) break;
    end
  endtask

  task automatic wait_negedges(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////

  function automatic logic [7:0] width_mask(input int unsigned nbits);
    return 8'((16'd1 << nbits) - 16'd1);
  endfunction

  function automatic logic expected_parity(input logic [7:0] data, input par_sel_t sel);
    int unsigned ones;
    ones = 0;
    for (int unsigned i = 0; i < 8; i++) begin
      if (data[i]) ones++;
    end
    case (sel)
      PAR_ODD:  return (ones % 2) == 0;  // Makes total count odd
      PAR_EVEN: return (ones % 2) == 1;
      PAR_ONE:  return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  // Serial decoder, samples mid-bit at negedges
  task automatic receive_frame(input logic [7:0] lcr, input int unsigned div,
                               input logic [7:0] ch);
    int unsigned nbits;
    int unsigned stop_len;
    int unsigned waited;
    logic [7:0]  data;
    logic [7:0]  exp_data;
    logic        all_high;
    nbits    = 5 + int'(lcr[1:0]);
    exp_data = ch & width_mask(nbits);
    if (!lcr[2]) stop_len = div;
    else if (nbits == 5) stop_len = (3 * div) / 2;  // 1.5 stop bits
    else stop_len = 2 * div;
    waited = 0;
    @(negedge clk);
    while (txd !== 1'b0 && waited < 3 * div + 8) begin
      @(negedge clk);
      waited++;
    end
    if (txd !== 1'b0) begin
      errors++;
      $display("Missing start bit: txd_o stayed high for %0d cycles at %0t", waited, $time);
      return;
    end
    wait_negedges(div / 2);
    check_bit(txd, 1'b0, "start bit");
    data = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      wait_negedges(div);
      data[i] = txd;  // LSB first
    end
    check_char(data, exp_data, "data bits");
    if (lcr[3]) begin
      wait_negedges(div);
      check_bit(txd, expected_parity(exp_data, par_sel_t'(lcr[5:4])), "parity bit");
    end
    wait_negedges(div - div / 2);  // First cycle of stop bits
    all_high = 1'b1;
    for (int unsigned j = 0; j < stop_len; j++) begin
      if (j > 0) @(negedge clk);
      all_high &= txd;
    end
    check_bit(all_high, 1'b1, "stop bits high");
  endtask

  ////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////

  task automatic check_after_reset();
    logic [7:0] rd;
    logic       line_high;
    line_high = 1'b1;
    repeat (8) begin
      @(negedge clk);
      line_high &= txd;
    end
    check_bit(line_high, 1'b1, "idle line after reset");
    bus_read(REG_LSR, rd);
    check_reg(rd, LSR_IDLE, "LSR after reset");
    bus_read(REG_LCR, rd);
    check_reg(rd, 8'h00, "LCR after reset");
    bus_write(REG_LCR, 8'h80);  // DLAB on
    bus_read(REG_THR_DLL, rd);
    check_reg(rd, 8'h00, "DLL after reset");
    bus_read(REG_DLM, rd);
    check_reg(rd, 8'h00, "DLM after reset");
    bus_write(REG_THR_DLL, 8'h5a);
    bus_write(REG_DLM, 8'hc3);
    bus_read(REG_THR_DLL, rd);
    check_reg(rd, 8'h5a, "DLL readback");
    bus_read(REG_DLM, rd);
    check_reg(rd, 8'hc3, "DLM readback");
    bus_read(REG_LCR, rd);
    check_reg(rd, 8'h80, "LCR readback");
  endtask

  task automatic run_row(input frame_row_t row);
    logic [7:0] rd;
    set_line(row.lcr, row.div, row.fifo);
    bus_read(REG_LCR, rd);
    check_len(word_len_t'(rd[1:0]), word_len_t'(row.lcr[1:0]), "LCR word length");
    bus_write(REG_THR_DLL, row.ch);
    receive_frame(row.lcr, row.div, row.ch);
    wait_tx_idle(rd);
    check_reg(rd, LSR_IDLE, "LSR after frame");
  endtask

  task automatic run_burst();
    logic [7:0] burst [10];
    logic [7:0] rd;
    foreach (burst[i]) burst[i] = 8'($urandom);
    set_line(8'h03, 16'd4, 1'b1);
    fork
      begin
        foreach (burst[i]) bus_write(REG_THR_DLL, burst[i]);
        bus_read(REG_LSR, rd);
        check_bit(rd[LSR_THR_EMPTY], 1'b0, "THR empty right after burst");
      end
      begin
        foreach (burst[i]) receive_frame(8'h03, 4, burst[i]);  // In order
      end
    join
    wait_tx_idle(rd);
    check_bit(rd[LSR_TX_EMPTY], 1'b1, "TX empty after burst");
  endtask

  task automatic run_fifo_reset();
    logic [7:0] chars [4];
    logic       line_high;
    foreach (chars[i]) chars[i] = 8'($urandom);
    set_line(8'h03, 16'd6, 1'b1);
    fork
      begin
        foreach (chars[i]) bus_write(REG_THR_DLL, chars[i]);
        bus_write(REG_FCR, 8'h05);  // Enable kept, TX FIFO reset
      end
      begin
        receive_frame(8'h03, 6, chars[0]);  // Already in the shifter
        line_high = 1'b1;
        repeat (12 * 6) begin
          @(negedge clk);
          line_high &= txd;
        end
        check_bit(line_high, 1'b1, "idle line after FIFO reset");
      end
    join
  endtask

  task automatic run_break();
    logic       line_low;
    logic [7:0] ch;
    set_line(8'h03, 16'd5, 1'b0);
    bus_write(REG_LCR, 8'h43);  // Break set
    line_low = 1'b1;
    repeat (3 * 5) begin
      @(negedge clk);
      line_low &= (txd === 1'b0);
    end
    check_bit(line_low, 1'b1, "line low during break");
    bus_write(REG_LCR, 8'h03);
    @(negedge clk);
    check_bit(txd, 1'b1, "line after break");
    ch = 8'($urandom);
    bus_write(REG_THR_DLL, ch);
    receive_frame(8'h03, 5, ch);
  endtask

  // Main sequence
  initial begin
    void'($urandom(45));
    arst_n   <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= 8'h00;
    rows[0] = '{lcr: 8'h03, div: 16'd4,  fifo: 1'b0, ch: 8'($urandom)};  // 8N1
    rows[1] = '{lcr: 8'h04, div: 16'd6,  fifo: 1'b0, ch: 8'($urandom)};  // 5 bits, 1.5 stop
    rows[2] = '{lcr: 8'h0b, div: 16'd5,  fifo: 1'b1, ch: 8'($urandom)};  // 8 bits, odd
    rows[3] = '{lcr: 8'h1a, div: 16'd7,  fifo: 1'b0, ch: 8'($urandom)};  // 7 bits, even
    rows[4] = '{lcr: 8'h29, div: 16'd8,  fifo: 1'b0, ch: 8'($urandom)};  // 6 bits, forced 1
    rows[5] = '{lcr: 8'h3f, div: 16'd10, fifo: 1'b1, ch: 8'($urandom)};  // Forced 0, 2 stop
    rows[6] = '{lcr: 8'h0c, div: 16'd9,  fifo: 1'b0, ch: 8'($urandom)};  // 5 bits, odd, 1.5
    rows[7] = '{lcr: 8'h1e, div: 16'd4,  fifo: 1'b0, ch: 8'($urandom)};  // 7 bits, even, 2
    cycle_limit = 2000;
    foreach (rows[r]) cycle_limit += 12 * rows[r].div;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    check_after_reset();
    foreach (rows[r]) run_row(rows[r]);
    run_burst();
    run_fifo_reset();
    run_break();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/uart_properties.sv
`timescale 1ns/100ps

module uart_properties (
  input logic clk_i,
  input logic arst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic txd_i
);

  // Ack is a single-cycle pulse
  ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o high for two cycles in a row");

  // No ack without an open access
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(wb_ack_i) |-> (wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o rose without cyc and stb");

  ////////////////////////////////////////
  // Line after reset
  ////////////////////////////////////////

  idle_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> txd_i)
    else $error("txd_o not high in the cycle after reset");

endmodule

bind uart_top uart_properties i_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_i (wb_ack_o),
  .txd_i    (txd_o)
);

// File: logic/uart_top.sv
`timescale 1ns/100ps

module uart_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [uart_pkg::ADDR_W-1:0]  wb_adr_i,
  input  logic [7:0]                   wb_dat_i,
  output logic [7:0]                   wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         txd_o
);

  import uart_pkg::*;

  ////////////////////////////////////////
  // Register bank to transmitter
  ////////////////////////////////////////

  logic [7:0]       thr_data;
  logic             thr_write;
  word_len_t        word_len;
  logic             stop_two;
  logic             par_en;
  par_sel_t         par_sel;
  logic             set_break;
  logic             fifo_en;
  logic             tx_fifo_rst;
  logic             thr_empty;   // Back to LSR
  logic             tx_empty;
  logic [DIV_W-1:0] divisor;
  logic             baud_tick;
  logic             half_tick;

  uart_regs i_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .thr_empty_i   (thr_empty),
    .tx_empty_i    (tx_empty),
    .thr_data_o    (thr_data),
    .thr_write_o   (thr_write),
    .word_len_o    (word_len),
    .stop_two_o    (stop_two),
    .par_en_o      (par_en),
    .par_sel_o     (par_sel),
    .set_break_o   (set_break),
    .fifo_en_o     (fifo_en),
    .tx_fifo_rst_o (tx_fifo_rst),
    .divisor_o     (divisor)
  );

  // Bit clock
  uart_baud_gen i_baud (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .divisor_i   (divisor),
    .baud_tick_o (baud_tick),
    .half_tick_o (half_tick)
  );

  uart_tx i_tx (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .baud_tick_i   (baud_tick),
    .half_tick_i   (half_tick),
    .thr_data_i    (thr_data),
    .thr_write_i   (thr_write),
    .word_len_i    (word_len),
    .stop_two_i    (stop_two),
    .par_en_i      (par_en),
    .par_sel_i     (par_sel),
    .set_break_i   (set_break),
    .fifo_en_i     (fifo_en),
    .tx_fifo_rst_i (tx_fifo_rst),
    .thr_empty_o   (thr_empty),
    .tx_empty_o    (tx_empty),
    .txd_o         (txd_o)
  );

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 baud_tick_i,
  input  logic                 half_tick_i,
  input  logic [7:0]           thr_data_i,
  input  logic                 thr_write_i,
  input  uart_pkg::word_len_t  word_len_i,
  input  logic                 stop_two_i,
  input  logic                 par_en_i,
  input  uart_pkg::par_sel_t   par_sel_i,
  input  logic                 set_break_i,
  input  logic                 fifo_en_i,
  input  logic                 tx_fifo_rst_i,
  output logic                 thr_empty_o,
  output logic                 tx_empty_o,
  output logic                 txd_o
);

  import uart_pkg::*;

  logic       fifo_flush;
  logic       fifo_push;
  logic       fifo_pop;
  logic       fifo_full;
  logic       fifo_empty;
  logic [7:0] fifo_data;

  logic       thr_full_q, thr_full_d;   // Holding register occupied
  tx_state_t  state_q, state_d;
  logic [7:0] tsr_q, tsr_d;             // Shift register, masked at load
  logic [2:0] bit_cnt_q, bit_cnt_d;
  logic       txd_q, txd_d;             // Line value, one bit time each

  logic [2:0] last_bit;
  logic [7:0] len_mask;
  logic       short_stop;               // 1.5 stop bits

  ////////////////////////////////////////
  // Character FIFO
  ////////////////////////////////////////

  uart_fifo i_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (fifo_flush),
    .push_i   (fifo_push),
    .data_i   (thr_data_i),
    .pop_i    (fifo_pop),
    .data_o   (fifo_data),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

  assign fifo_flush = tx_fifo_rst_i | ~fifo_en_i;  // Held empty in holding mode
  // THR drains into FIFO when there is space, not during a reset
  assign fifo_push  = fifo_en_i & thr_full_q & ~fifo_full & ~tx_fifo_rst_i;

  // Word length decode
  assign last_bit   = {1'b1, word_len_i};  // Index of last data bit, 4 to 7
  assign short_stop = (word_len_i == WLEN_5) & stop_two_i;

  always_comb begin
    case (word_len_i)
      WLEN_5:  len_mask = 8'h1f;
      WLEN_6:  len_mask = 8'h3f;
      WLEN_7:  len_mask = 8'h7f;
      default: len_mask = 8'hff;
    endcase
  end

  ////////////////////////////////////////
  // Transmit FSM
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    tsr_d      = tsr_q;
    bit_cnt_d  = bit_cnt_q;
    txd_d      = txd_q;
    fifo_pop   = 1'b0;
    thr_full_d = thr_full_q;

    // Holding register bookkeeping, a new write wins over the drain
    if (fifo_push) begin
      thr_full_d = 1'b0;
    end

    case (state_q)
      TX_IDLE: begin
        txd_d     = 1'b1;  // Line idles high
        bit_cnt_d = '0;
        if (fifo_en_i) begin
          if (!fifo_empty && !tx_fifo_rst_i) begin
            tsr_d    = fifo_data & len_mask;
            fifo_pop = 1'b1;
            state_d  = TX_START;
          end
        end else if (thr_full_q) begin
          tsr_d      = thr_data_i & len_mask;
          thr_full_d = 1'b0;
          state_d    = TX_START;
        end
      end

      TX_START: begin
        if (baud_tick_i) begin
          txd_d   = 1'b0;  // Start bit
          state_d = TX_DATA;
        end
      end

      TX_DATA: begin
        if (baud_tick_i) begin
          txd_d     = tsr_q[bit_cnt_q];  // LSB first
          bit_cnt_d = bit_cnt_q + 1'b1;
          if (bit_cnt_q == last_bit) begin
            state_d = par_en_i ? TX_PARITY : TX_STOP1;
          end
        end
      end

      TX_PARITY: begin
        if (baud_tick_i) begin
          case (par_sel_i)
            PAR_ODD:  txd_d = ~(^tsr_q);
            PAR_EVEN: txd_d = ^tsr_q;
            PAR_ONE:  txd_d = 1'b1;
            default:  txd_d = 1'b0;  // Forced 0
          endcase
          state_d = TX_STOP1;
        end
      end

      TX_STOP1: begin
        if (baud_tick_i) begin
          txd_d   = 1'b1;
          state_d = stop_two_i ? TX_STOP2 : TX_FINISH;
        end
      end

      TX_STOP2: begin
        if (baud_tick_i) begin
          state_d = TX_FINISH;  // Second stop bit begins
        end
      end

      TX_FINISH: begin
        // Last stop bit ends, half a bit early for short frames
        if (short_stop ? half_tick_i : baud_tick_i) begin
          state_d = TX_IDLE;
        end
      end

      default: state_d = TX_IDLE;
    endcase

    if (thr_write_i) begin
      thr_full_d = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= TX_IDLE;
      bit_cnt_q  <= '0;
      txd_q      <= 1'b1;  // Idle line after reset
      thr_full_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      bit_cnt_q  <= bit_cnt_d;
      txd_q      <= txd_d;
      thr_full_q <= thr_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    tsr_q <= tsr_d;
  end

  // Outputs
  assign txd_o       = txd_q & ~set_break_i;  // Break forces spacing
  assign thr_empty_o = ~thr_full_q & (~fifo_en_i | fifo_empty);
  assign tx_empty_o  = thr_empty_o & (state_q == TX_IDLE);

endmodule

// File: logic/uart_baud_gen.sv
`timescale 1ns/100ps

module uart_baud_gen (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic [uart_pkg::DIV_W-1:0]  divisor_i,
  output logic                        baud_tick_o,   // One per bit period
  output logic                        half_tick_o    // Baud tick plus mid-period tick
);

  import uart_pkg::*;

  logic [DIV_W-1:0] cnt_q;
  logic [DIV_W-1:0] div_q;   // Last divisor seen
  logic             div_changed;
  logic             run;

  assign div_changed = (divisor_i != div_q);
  assign run         = (divisor_i != '0) & ~div_changed;  // Zero divisor stops both ticks

  assign baud_tick_o = run & (cnt_q == '0);
  assign half_tick_o = baud_tick_o | (run & (cnt_q == (divisor_i >> 1)));

  ////////////////////////////////////////
  // Down-counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      div_q <= '0;
    end else begin
      div_q <= divisor_i;
      if (divisor_i == '0) begin
        cnt_q <= '0;
      end else if (div_changed || (cnt_q == '0)) begin
        cnt_q <= divisor_i - 1'b1;  // Restart on new divisor or reload after tick
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// File: logic/uart_regs.sv
`timescale 1ns/100ps

module uart_regs (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Wishbone classic slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [uart_pkg::ADDR_W-1:0]  wb_adr_i,
  input  logic [7:0]                   wb_dat_i,
  output logic [7:0]                   wb_dat_o,
  output logic                         wb_ack_o,
  // Status from transmitter
  input  logic                         thr_empty_i,
  input  logic                         tx_empty_i,
  // Transmit control
  output logic [7:0]                   thr_data_o,
  output logic                         thr_write_o,
  output uart_pkg::word_len_t          word_len_o,
  output logic                         stop_two_o,
  output logic                         par_en_o,
  output uart_pkg::par_sel_t           par_sel_o,
  output logic                         set_break_o,
  output logic                         fifo_en_o,
  output logic                         tx_fifo_rst_o,
  output logic [uart_pkg::DIV_W-1:0]   divisor_o
);

  import uart_pkg::*;

  logic             ack_q;
  logic             access;    // First cycle of a bus access
  logic             wr_en;
  logic             dlab;
  logic [7:0]       lcr_q;
  logic             fifo_en_q;
  logic [DIV_W-1:0] div_q;
  logic [7:0]       thr_q;
  logic [7:0]       rd_data;
  logic [7:0]       dat_q;

  assign access = wb_cyc_i & wb_stb_i & ~ack_q;  // Ack drops the access for one cycle
  assign wr_en  = access & wb_we_i;
  assign dlab   = lcr_q[7];

  ////////////////////////////////////////
  // Write strobes, valid in the ack cycle before
  ////////////////////////////////////////

  assign thr_write_o   = wr_en & (wb_adr_i == REG_THR_DLL) & ~dlab;
  assign tx_fifo_rst_o = wr_en & (wb_adr_i == REG_FCR) & wb_dat_i[2];  // Bit 2 self-clears

  // Read mux
  always_comb begin
    logic [7:0] lsr;
    lsr                = '0;
    lsr[LSR_THR_EMPTY] = thr_empty_i;
    lsr[LSR_TX_EMPTY]  = tx_empty_i;
    case (wb_adr_i)
      REG_THR_DLL: rd_data = dlab ? div_q[7:0] : 8'h00;   // RBR not present
      REG_DLM:     rd_data = dlab ? div_q[15:8] : 8'h00;  // IER not present
      REG_LCR:     rd_data = lcr_q;
      REG_LSR:     rd_data = lsr;
      default:     rd_data = 8'h00;  // Unmapped, still acked
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q     <= 1'b0;
      lcr_q     <= '0;   // 5-bit words, no parity
      fifo_en_q <= 1'b0;
      div_q     <= '0;   // Baud ticks stopped
    end else begin
      ack_q <= access;
      if (wr_en) begin
        case (wb_adr_i)
          REG_THR_DLL: if (dlab) div_q[7:0] <= wb_dat_i;
          REG_DLM:     if (dlab) div_q[15:8] <= wb_dat_i;
          REG_FCR:     fifo_en_q <= wb_dat_i[0];
          REG_LCR:     lcr_q <= wb_dat_i;
          default: ;
        endcase
      end
    end
  end

  // Holding register and read data
  always_ff @(posedge clk_i) begin
    if (thr_write_o) begin
      thr_q <= wb_dat_i;
    end
    if (access) begin
      dat_q <= rd_data;  // Held while ack is high
    end
  end

  assign wb_ack_o    = ack_q;
  assign wb_dat_o    = dat_q;
  assign thr_data_o  = thr_q;
  assign word_len_o  = word_len_t'(lcr_q[1:0]);
  assign stop_two_o  = lcr_q[2];
  assign par_en_o    = lcr_q[3];
  assign par_sel_o   = par_sel_t'(lcr_q[5:4]);
  assign set_break_o = lcr_q[6];
  assign fifo_en_o   = fifo_en_q;
  assign divisor_o   = div_q;

endmodule

// File: logic/uart_fifo.sv
`timescale 1ns/100ps

module uart_fifo (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       flush_i,
  input  logic       push_i,
  input  logic [7:0] data_i,
  input  logic       pop_i,
  output logic [7:0] data_o,   // Head entry
  output logic       full_o,
  output logic       empty_o
);

  import uart_pkg::*;

  logic [7:0]          mem [TX_FIFO_DEPTH];
  logic [FIFO_PTR_W:0] wr_ptr_q;   // MSB is the wrap bit
  logic [FIFO_PTR_W:0] rd_ptr_q;
  logic                push_ok;
  logic                pop_ok;

  // Same index, different wrap means full
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[FIFO_PTR_W] != rd_ptr_q[FIFO_PTR_W])
                 & (wr_ptr_q[FIFO_PTR_W-1:0] == rd_ptr_q[FIFO_PTR_W-1:0]);

  assign push_ok = push_i & ~full_o;   // Dropped when full
  assign pop_ok  = pop_i & ~empty_o;   // Ignored when empty

  assign data_o = mem[rd_ptr_q[FIFO_PTR_W-1:0]];

  ////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;  // Empty in one cycle
      rd_ptr_q <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok && !flush_i) begin
      mem[wr_ptr_q[FIFO_PTR_W-1:0]] <= data_i;
    end
  end

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned ADDR_W        = 3;   // Wishbone register address
  localparam int unsigned DIV_W         = 16;  // Baud divisor
  localparam int unsigned TX_FIFO_DEPTH = 16;  // Character entries
  localparam int unsigned FIFO_PTR_W    = 4;   // log2 of depth, wrap bit added on top

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // DLAB set steers addresses 0 and 1 to the divisor bytes
  localparam logic [ADDR_W-1:0] REG_THR_DLL = 3'd0;
  localparam logic [ADDR_W-1:0] REG_DLM     = 3'd1;
  localparam logic [ADDR_W-1:0] REG_FCR     = 3'd2;
  localparam logic [ADDR_W-1:0] REG_LCR     = 3'd3;
  localparam logic [ADDR_W-1:0] REG_LSR     = 3'd5;

  // LSR bit positions
  localparam int unsigned LSR_THR_EMPTY = 5;
  localparam int unsigned LSR_TX_EMPTY  = 6;

  ////////////////////////////////////////
  // Field encodings
  ////////////////////////////////////////

  // LCR[1:0]
  typedef enum logic [1:0] {
    WLEN_5 = 2'd0,
    WLEN_6 = 2'd1,
    WLEN_7 = 2'd2,
    WLEN_8 = 2'd3
  } word_len_t;

  // LCR[5:4], stick parity in the upper half
  typedef enum logic [1:0] {
    PAR_ODD  = 2'd0,
    PAR_EVEN = 2'd1,
    PAR_ONE  = 2'd2,
    PAR_ZERO = 2'd3
  } par_sel_t;

  // Transmit FSM
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP1,
    TX_STOP2,
    TX_FINISH
  } tx_state_t;

endpackage
